//--- tests/mempool_input.txt
// Batch, port, write, paddr, pwdata, pslverr, prdata, alternate prdata (all hex)
// prdata is checked on reads and error responses; batch ff ends the list
00 0 1 00000004 11110001 0 00000000 00000000
00 3 1 000001cc 44440004 0 00000000 00000000
01 0 0 00000004 00000000 0 11110001 11110001
01 3 0 000001cc 00000000 0 44440004 44440004
02 0 1 00000090 0a0a0090 0 00000000 00000000
03 0 1 00000150 0b0b0150 0 00000000 00000000
04 0 1 00000194 0c0c0194 0 00000000 00000000
04 1 1 00000000 5a5a0000 0 00000000 00000000
05 1 0 00000090 00000000 0 0a0a0090 0a0a0090
05 2 0 00000150 00000000 0 0b0b0150 0b0b0150
05 3 0 00000194 00000000 0 0c0c0194 0c0c0194
05 0 0 00000000 00000000 0 5a5a0000 5a5a0000
06 0 1 00000120 d0d00120 0 00000000 00000000
06 1 1 00000124 d1d10124 0 00000000 00000000
06 2 1 00000128 d2d20128 0 00000000 00000000
06 3 1 0000012c d3d3012c 0 00000000 00000000
07 0 0 0000012c 00000000 0 d3d3012c d3d3012c
07 1 0 00000120 00000000 0 d0d00120 d0d00120
07 2 0 00000124 00000000 0 d1d10124 d1d10124
07 3 0 00000128 00000000 0 d2d20128 d2d20128
08 1 1 000001f0 aaaa01f0 0 00000000 00000000
08 3 1 000001f0 bbbb01f0 0 00000000 00000000
09 0 0 000001f0 00000000 0 aaaa01f0 bbbb01f0
09 2 0 000001f0 00000000 0 aaaa01f0 bbbb01f0
0a 2 1 00000200 deadbeef 1 00000000 00000000
0a 3 0 00000400 00000000 1 00000000 00000000
0b 0 0 00000000 00000000 0 5a5a0000 5a5a0000
ff 0 0 00000000 00000000 0 00000000 00000000

//--- filelist.f
+incdir+hw
hw/apb_pkg.sv
hw/mempool_pkg.sv
hw/tcdm_bank.sv
hw/tcdm_group_xbar.sv
hw/apb_tcdm_adapter.sv
hw/mempool_group.sv
hw/mempool_cluster.sv
tests/tb_mempool_cluster.sv

//--- run.sh
#!/usr/bin/env bash
# Build the cluster testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary -j 0 --top-module tb_mempool_cluster -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output="$(./obj_dir/Vtb_mempool_cluster)"
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

printf '%s\n' "$sim_output" | grep -qx "STATUS: PASS"
if [ $? -ne 0 ]; then
  exit 1
fi
exit 0

//--- tests/tb_mempool_cluster.sv
/* Cluster testbench that replays APB batches from the input file on the
   four ports and checks pslverr and read data, with a run time watchdog */
`include "mempool_defines.svh"

module tb_mempool_cluster;
  import apb_pkg::*;

  localparam int num_ports    = `MEMPOOL_NUM_GROUPS;
  localparam int rec_words    = 8;
  localparam int max_ops      = 64;
  localparam int clk_period   = 20;
  localparam int reset_cycles = 16;
  localparam int op_cycles    = 40;

  // APB phase of each port within a batch
  localparam int ph_idle   = 0;
  localparam int ph_setup  = 1;
  localparam int ph_access = 2;
  localparam int ph_done   = 3;

  logic clk;
  logic rst;
  apb_req_t  [num_ports-1:0] apb_req;
  apb_resp_t [num_ports-1:0] apb_resp;

  // Eight words per record, from batch number to alternate prdata
  logic [31:0] stim [rec_words*max_ops];

  int num_ops;
  bit loaded;
  int mismatch_count;
  int other_count;
  int rec_of [num_ports];
  int phase  [num_ports];

  mempool_cluster mempool_cluster_inst (
    .clk_i      (clk),
    .rst_i      (rst),
    .apb_req_i  (apb_req),
    .apb_resp_o (apb_resp)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] stim_field(input int rec, input int col);
    return stim[rec * rec_words + col];
  endfunction

  task automatic finish_run();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // Records up to the batch ff marker
  task automatic load_stimulus();
    $readmemh("tests/mempool_input.txt", stim);
    num_ops = 0;
    while (num_ops < max_ops && stim_field(num_ops, 0) != 32'hff) begin
      num_ops++;
    end
    if (num_ops == 0 || num_ops == max_ops || stim_field(num_ops, 0) !== 32'hff) begin
      other_count++;
      $display("Input file is missing, empty or lacks its end marker");
      num_ops = 0;
    end
  endtask

  task automatic check_response(input int port);
    int          r;
    logic [31:0] exp_err;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    bit          check_data;
    r       = rec_of[port];
    exp_err = stim_field(r, 5);
    exp_a   = stim_field(r, 6);
    exp_b   = stim_field(r, 7);
    // Data compared on reads and on error responses
    check_data = (stim_field(r, 2) == 32'h0) || (exp_err != 32'h0);
    if (apb_resp[port].pslverr !== exp_err[0]) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=apb_resp_o[%0d].pslverr expected=%0b actual=%0b",
               $time, port, exp_err[0], apb_resp[port].pslverr);
    end
    if (check_data && apb_resp[port].prdata !== exp_a && apb_resp[port].prdata !== exp_b) begin
      mismatch_count++;
      $display("MISMATCH time=%0t signal=apb_resp_o[%0d].prdata expected=%08h or %08h actual=%08h",
               $time, port, exp_a, exp_b, apb_resp[port].prdata);
    end
  endtask

  // Records of a batch start together and each port ends on its own pready
  task automatic run_batch(input int first, input int last);
    int p;
    bit busy;
    for (int i = 0; i < num_ports; i++) begin
      phase[i] = ph_idle;
    end
    @(posedge clk);
    #1;
    for (int r = first; r <= last; r++) begin
      p = int'(stim_field(r, 1));
      if (p < 0 || p >= num_ports || phase[p] != ph_idle) begin
        other_count++;
        $display("Input record %0d names an invalid or already used port %0d", r, p);
      end else begin
        rec_of[p]          = r;
        phase[p]           = ph_setup;
        apb_req[p].psel    = 1'b1;
        apb_req[p].penable = 1'b0;
        apb_req[p].pwrite  = (stim_field(r, 2) != 32'h0);
        apb_req[p].paddr   = stim_field(r, 3);
        apb_req[p].pwdata  = stim_field(r, 4);
      end
    end
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      #1;
      for (int i = 0; i < num_ports; i++) begin
        if (phase[i] == ph_setup) begin
          apb_req[i].penable = 1'b1;
          phase[i]           = ph_access;
        end else if (phase[i] == ph_done) begin
          apb_req[i] = '0;
          phase[i]   = ph_idle;
        end
      end
      // Outputs settled at mid-cycle
      @(negedge clk);
      busy = 1'b0;
      for (int i = 0; i < num_ports; i++) begin
        if (phase[i] == ph_access && apb_resp[i].pready) begin
          check_response(i);
          phase[i] = ph_done;
        end
        if (phase[i] != ph_idle) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  initial begin : main
    int first;
    int last;
    rst            = 1'b1;
    apb_req        = '0;
    mismatch_count = 0;
    other_count    = 0;
    load_stimulus();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst   = 1'b0;
    first = 0;
    while (first < num_ops) begin
      last = first;
      while (last + 1 < num_ops && stim_field(last + 1, 0) == stim_field(first, 0)) begin
        last++;
      end
      run_batch(first, last);
      first = last + 1;
    end
    finish_run();
  end

  initial begin : watchdog
    wait (loaded);
    #((reset_cycles + 2 + num_ops * op_cycles) * clk_period);
    other_count++;
    $display("Timeout: the run did not complete within %0d cycles",
             reset_cycles + 2 + num_ops * op_cycles);
    finish_run();
  end

endmodule

//--- hw/mempool_cluster.sv
/* Cluster top: four groups with one APB port each, links wired to the
   partner group found by XOR of the group index */
`include "mempool_defines.svh"

module mempool_cluster (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  apb_pkg::apb_req_t  [`MEMPOOL_NUM_GROUPS-1:0]   apb_req_i,
  output apb_pkg::apb_resp_t [`MEMPOOL_NUM_GROUPS-1:0]   apb_resp_o
);
  import mempool_pkg::*;

  localparam int unsigned num_groups = `MEMPOOL_NUM_GROUPS;

  // Indexed by direction, then by the group driving the signal
  tcdm_req_t  mst_req        [num_links-1:1][num_groups];
  logic       mst_req_valid  [num_links-1:1][num_groups];
  logic       mst_resp_ready [num_links-1:1][num_groups];
  logic       slv_req_ready  [num_links-1:1][num_groups];
  tcdm_resp_t slv_resp       [num_links-1:1][num_groups];
  logic       slv_resp_valid [num_links-1:1][num_groups];

  // Group g talks to group g ^ d over the link of direction d
  for (genvar g = 0; g < num_groups; g++) begin : gen_groups
    mempool_group i_group (
      .clk_i                              (clk_i),
      .rst_i                              (rst_i),
      .group_id_i                         (group_id_t'(g)),
      .apb_req_i                          (apb_req_i[g]),
      .apb_resp_o                         (apb_resp_o[g]),
      .tcdm_master_north_req_o            (mst_req[link_north][g]),
      .tcdm_master_north_req_valid_o      (mst_req_valid[link_north][g]),
      .tcdm_master_north_req_ready_i      (slv_req_ready[link_north][g ^ link_north]),
      .tcdm_master_north_resp_i           (slv_resp[link_north][g ^ link_north]),
      .tcdm_master_north_resp_valid_i     (slv_resp_valid[link_north][g ^ link_north]),
      .tcdm_master_north_resp_ready_o     (mst_resp_ready[link_north][g]),
      .tcdm_master_east_req_o             (mst_req[link_east][g]),
      .tcdm_master_east_req_valid_o       (mst_req_valid[link_east][g]),
      .tcdm_master_east_req_ready_i       (slv_req_ready[link_east][g ^ link_east]),
      .tcdm_master_east_resp_i            (slv_resp[link_east][g ^ link_east]),
      .tcdm_master_east_resp_valid_i      (slv_resp_valid[link_east][g ^ link_east]),
      .tcdm_master_east_resp_ready_o      (mst_resp_ready[link_east][g]),
      .tcdm_master_northeast_req_o        (mst_req[link_northeast][g]),
      .tcdm_master_northeast_req_valid_o  (mst_req_valid[link_northeast][g]),
      .tcdm_master_northeast_req_ready_i  (slv_req_ready[link_northeast][g ^ link_northeast]),
      .tcdm_master_northeast_resp_i       (slv_resp[link_northeast][g ^ link_northeast]),
      .tcdm_master_northeast_resp_valid_i (slv_resp_valid[link_northeast][g ^ link_northeast]),
      .tcdm_master_northeast_resp_ready_o (mst_resp_ready[link_northeast][g]),
      .tcdm_slave_north_req_i             (mst_req[link_north][g ^ link_north]),
      .tcdm_slave_north_req_valid_i       (mst_req_valid[link_north][g ^ link_north]),
      .tcdm_slave_north_req_ready_o       (slv_req_ready[link_north][g]),
      .tcdm_slave_north_resp_o            (slv_resp[link_north][g]),
      .tcdm_slave_north_resp_valid_o      (slv_resp_valid[link_north][g]),
      .tcdm_slave_north_resp_ready_i      (mst_resp_ready[link_north][g ^ link_north]),
      .tcdm_slave_east_req_i              (mst_req[link_east][g ^ link_east]),
      .tcdm_slave_east_req_valid_i        (mst_req_valid[link_east][g ^ link_east]),
      .tcdm_slave_east_req_ready_o        (slv_req_ready[link_east][g]),
      .tcdm_slave_east_resp_o             (slv_resp[link_east][g]),
      .tcdm_slave_east_resp_valid_o       (slv_resp_valid[link_east][g]),
      .tcdm_slave_east_resp_ready_i       (mst_resp_ready[link_east][g ^ link_east]),
      .tcdm_slave_northeast_req_i         (mst_req[link_northeast][g ^ link_northeast]),
      .tcdm_slave_northeast_req_valid_i   (mst_req_valid[link_northeast][g ^ link_northeast]),
      .tcdm_slave_northeast_req_ready_o   (slv_req_ready[link_northeast][g]),
      .tcdm_slave_northeast_resp_o        (slv_resp[link_northeast][g]),
      .tcdm_slave_northeast_resp_valid_o  (slv_resp_valid[link_northeast][g]),
      .tcdm_slave_northeast_resp_ready_i  (mst_resp_ready[link_northeast][g ^ link_northeast])
    );
  end

endmodule

//--- hw/mempool_group.sv
/* One group with its APB adapter, crossbar, banks and the north, east
   and northeast master and slave links */
`include "mempool_defines.svh"

module mempool_group (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mempool_pkg::group_id_t  group_id_i,
  input  apb_pkg::apb_req_t       apb_req_i,
  output apb_pkg::apb_resp_t      apb_resp_o,
  // Master links
  output mempool_pkg::tcdm_req_t  tcdm_master_north_req_o,
  output logic                    tcdm_master_north_req_valid_o,
  input  logic                    tcdm_master_north_req_ready_i,
  input  mempool_pkg::tcdm_resp_t tcdm_master_north_resp_i,
  input  logic                    tcdm_master_north_resp_valid_i,
  output logic                    tcdm_master_north_resp_ready_o,
  output mempool_pkg::tcdm_req_t  tcdm_master_east_req_o,
  output logic                    tcdm_master_east_req_valid_o,
  input  logic                    tcdm_master_east_req_ready_i,
  input  mempool_pkg::tcdm_resp_t tcdm_master_east_resp_i,
  input  logic                    tcdm_master_east_resp_valid_i,
  output logic                    tcdm_master_east_resp_ready_o,
  output mempool_pkg::tcdm_req_t  tcdm_master_northeast_req_o,
  output logic                    tcdm_master_northeast_req_valid_o,
  input  logic                    tcdm_master_northeast_req_ready_i,
  input  mempool_pkg::tcdm_resp_t tcdm_master_northeast_resp_i,
  input  logic                    tcdm_master_northeast_resp_valid_i,
  output logic                    tcdm_master_northeast_resp_ready_o,
  // Slave links into the banks
  input  mempool_pkg::tcdm_req_t  tcdm_slave_north_req_i,
  input  logic                    tcdm_slave_north_req_valid_i,
  output logic                    tcdm_slave_north_req_ready_o,
  output mempool_pkg::tcdm_resp_t tcdm_slave_north_resp_o,
  output logic                    tcdm_slave_north_resp_valid_o,
  input  logic                    tcdm_slave_north_resp_ready_i,
  input  mempool_pkg::tcdm_req_t  tcdm_slave_east_req_i,
  input  logic                    tcdm_slave_east_req_valid_i,
  output logic                    tcdm_slave_east_req_ready_o,
  output mempool_pkg::tcdm_resp_t tcdm_slave_east_resp_o,
  output logic                    tcdm_slave_east_resp_valid_o,
  input  logic                    tcdm_slave_east_resp_ready_i,
  input  mempool_pkg::tcdm_req_t  tcdm_slave_northeast_req_i,
  input  logic                    tcdm_slave_northeast_req_valid_i,
  output logic                    tcdm_slave_northeast_req_ready_o,
  output mempool_pkg::tcdm_resp_t tcdm_slave_northeast_resp_o,
  output logic                    tcdm_slave_northeast_resp_valid_o,
  input  logic                    tcdm_slave_northeast_resp_ready_i
);
  import mempool_pkg::*;

  localparam int unsigned num_banks = `MEMPOOL_BANKS_PER_GROUP;

  // Adapter port into this group's own banks
  tcdm_req_t  local_req;
  logic       local_req_valid;
  logic       local_req_ready;
  tcdm_resp_t local_resp;
  logic       local_resp_valid;
  logic       local_resp_ready;

  tcdm_req_t  [num_banks-1:0] bank_req;
  logic       [num_banks-1:0] bank_req_valid;
  logic       [num_banks-1:0] bank_req_ready;
  tcdm_resp_t [num_banks-1:0] bank_resp;
  logic       [num_banks-1:0] bank_resp_valid;
  logic       [num_banks-1:0] bank_resp_ready;

  // Concatenations list northeast, north, east and local from the top
  apb_tcdm_adapter i_adapter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .group_id_i   (group_id_i),
    .apb_req_i    (apb_req_i),
    .apb_resp_o   (apb_resp_o),
    .req_o        ({tcdm_master_northeast_req_o, tcdm_master_north_req_o,
                    tcdm_master_east_req_o, local_req}),
    .req_valid_o  ({tcdm_master_northeast_req_valid_o, tcdm_master_north_req_valid_o,
                    tcdm_master_east_req_valid_o, local_req_valid}),
    .req_ready_i  ({tcdm_master_northeast_req_ready_i, tcdm_master_north_req_ready_i,
                    tcdm_master_east_req_ready_i, local_req_ready}),
    .resp_i       ({tcdm_master_northeast_resp_i, tcdm_master_north_resp_i,
                    tcdm_master_east_resp_i, local_resp}),
    .resp_valid_i ({tcdm_master_northeast_resp_valid_i, tcdm_master_north_resp_valid_i,
                    tcdm_master_east_resp_valid_i, local_resp_valid}),
    .resp_ready_o ({tcdm_master_northeast_resp_ready_o, tcdm_master_north_resp_ready_o,
                    tcdm_master_east_resp_ready_o, local_resp_ready})
  );

  tcdm_group_xbar i_xbar (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .src_req_i         ({tcdm_slave_northeast_req_i, tcdm_slave_north_req_i,
                         tcdm_slave_east_req_i, local_req}),
    .src_req_valid_i   ({tcdm_slave_northeast_req_valid_i, tcdm_slave_north_req_valid_i,
                         tcdm_slave_east_req_valid_i, local_req_valid}),
    .src_req_ready_o   ({tcdm_slave_northeast_req_ready_o, tcdm_slave_north_req_ready_o,
                         tcdm_slave_east_req_ready_o, local_req_ready}),
    .src_resp_o        ({tcdm_slave_northeast_resp_o, tcdm_slave_north_resp_o,
                         tcdm_slave_east_resp_o, local_resp}),
    .src_resp_valid_o  ({tcdm_slave_northeast_resp_valid_o, tcdm_slave_north_resp_valid_o,
                         tcdm_slave_east_resp_valid_o, local_resp_valid}),
    .src_resp_ready_i  ({tcdm_slave_northeast_resp_ready_i, tcdm_slave_north_resp_ready_i,
                         tcdm_slave_east_resp_ready_i, local_resp_ready}),
    .bank_req_o        (bank_req),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_ready_i  (bank_req_ready),
    .bank_resp_i       (bank_resp),
    .bank_resp_valid_i (bank_resp_valid),
    .bank_resp_ready_o (bank_resp_ready)
  );

  for (genvar b = 0; b < num_banks; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_i        (bank_req[b]),
      .req_valid_i  (bank_req_valid[b]),
      .req_ready_o  (bank_req_ready[b]),
      .resp_o       (bank_resp[b]),
      .resp_valid_o (bank_resp_valid[b]),
      .resp_ready_i (bank_resp_ready[b])
    );
  end

endmodule

//--- hw/apb_tcdm_adapter.sv
/* APB completer that turns each access into one TCDM request on the
   link toward the owning group and waits for its response */
`include "mempool_defines.svh"

module apb_tcdm_adapter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  mempool_pkg::group_id_t                               group_id_i,
  input  apb_pkg::apb_req_t                                    apb_req_i,
  output apb_pkg::apb_resp_t                                   apb_resp_o,
  // TCDM master ports, indexed by link direction
  output mempool_pkg::tcdm_req_t  [mempool_pkg::num_links-1:0] req_o,
  output logic                    [mempool_pkg::num_links-1:0] req_valid_o,
  input  logic                    [mempool_pkg::num_links-1:0] req_ready_i,
  input  mempool_pkg::tcdm_resp_t [mempool_pkg::num_links-1:0] resp_i,
  input  logic                    [mempool_pkg::num_links-1:0] resp_valid_i,
  output logic                    [mempool_pkg::num_links-1:0] resp_ready_o
);
  import mempool_pkg::*;

  typedef enum logic [1:0] {st_idle, st_request, st_wait_resp} state_e;

  state_e     state_q;
  state_e     state_d;
  tcdm_addr_t addr;
  tcdm_req_t  req;
  link_dir_t  link;
  logic       access;
  logic       out_of_range;

  // Word address right above the byte offset
  assign addr         = apb_req_i.paddr[$bits(tcdm_addr_t)+1:2];
  assign out_of_range = |apb_req_i.paddr[`MEMPOOL_ADDR_WIDTH-1:$bits(tcdm_addr_t)+2];
  assign link         = link_dir_t'(addr.group ^ group_id_i);
  assign access       = apb_req_i.psel && apb_req_i.penable;

  assign req   = '{addr: addr, write: apb_req_i.pwrite, wdata: apb_req_i.pwdata};
  // Same payload on all links and only the selected one valid
  assign req_o = {num_links{req}};

  always_comb begin
    state_d      = state_q;
    req_valid_o  = '0;
    resp_ready_o = '0;
    apb_resp_o   = '0;
    case (state_q)
      st_idle: begin
        if (access && out_of_range) begin
          apb_resp_o.pready  = 1'b1;
          apb_resp_o.pslverr = 1'b1;
        end else if (access) begin
          state_d = st_request;
        end
      end
      st_request: begin
        req_valid_o[link] = 1'b1;
        if (req_ready_i[link]) begin
          state_d = st_wait_resp;
        end
      end
      st_wait_resp: begin
        resp_ready_o[link] = 1'b1;
        if (resp_valid_i[link]) begin
          apb_resp_o.pready = 1'b1;
          apb_resp_o.prdata = resp_i[link].rdata;
          state_d           = st_idle;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- hw/tcdm_group_xbar.sv
/* Group crossbar: per-bank round-robin arbitration among the local and
   three link sources, and tag-based routing of bank responses */
`include "mempool_defines.svh"

module tcdm_group_xbar (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  // Sources, indexed by link direction
  input  mempool_pkg::tcdm_req_t  [mempool_pkg::num_links-1:0]   src_req_i,
  input  logic                    [mempool_pkg::num_links-1:0]   src_req_valid_i,
  output logic                    [mempool_pkg::num_links-1:0]   src_req_ready_o,
  output mempool_pkg::tcdm_resp_t [mempool_pkg::num_links-1:0]   src_resp_o,
  output logic                    [mempool_pkg::num_links-1:0]   src_resp_valid_o,
  input  logic                    [mempool_pkg::num_links-1:0]   src_resp_ready_i,
  // Banks
  output mempool_pkg::tcdm_req_t  [`MEMPOOL_BANKS_PER_GROUP-1:0] bank_req_o,
  output logic                    [`MEMPOOL_BANKS_PER_GROUP-1:0] bank_req_valid_o,
  input  logic                    [`MEMPOOL_BANKS_PER_GROUP-1:0] bank_req_ready_i,
  input  mempool_pkg::tcdm_resp_t [`MEMPOOL_BANKS_PER_GROUP-1:0] bank_resp_i,
  input  logic                    [`MEMPOOL_BANKS_PER_GROUP-1:0] bank_resp_valid_i,
  output logic                    [`MEMPOOL_BANKS_PER_GROUP-1:0] bank_resp_ready_o
);
  import mempool_pkg::*;

  localparam int unsigned num_banks = `MEMPOOL_BANKS_PER_GROUP;

  // Round-robin pointer, owner of the pending response, current grant
  link_dir_t ptr_q [num_banks];
  link_dir_t tag_q [num_banks];
  link_dir_t gnt   [num_banks];

  always_comb begin : req_arb
    link_dir_t idx;
    idx             = link_local;
    src_req_ready_o = '0;
    for (int b = 0; b < num_banks; b++) begin
      gnt[b]              = ptr_q[b];
      bank_req_valid_o[b] = 1'b0;
      // Walk down so the requester nearest the pointer wins
      for (int i = num_links - 1; i >= 0; i--) begin
        idx = link_dir_t'(2'(ptr_q[b] + i));
        if (src_req_valid_i[idx] && int'(src_req_i[idx].addr.bank) == b) begin
          gnt[b]              = idx;
          bank_req_valid_o[b] = 1'b1;
        end
      end
      bank_req_o[b]             = src_req_i[gnt[b]];
      src_req_ready_o[gnt[b]] |= bank_req_valid_o[b] && bank_req_ready_i[b];
    end
  end

  // Lowest bank first if two responses ever target one source
  always_comb begin : resp_route
    src_resp_o        = '0;
    src_resp_valid_o  = '0;
    bank_resp_ready_o = '0;
    for (int b = 0; b < num_banks; b++) begin
      if (bank_resp_valid_i[b] && !src_resp_valid_o[tag_q[b]]) begin
        src_resp_o[tag_q[b]]       = bank_resp_i[b];
        src_resp_valid_o[tag_q[b]] = 1'b1;
        bank_resp_ready_o[b]       = src_resp_ready_i[tag_q[b]];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < num_banks; b++) begin
      if (rst_i) begin
        ptr_q[b] <= link_local;
        tag_q[b] <= link_local;
      end else if (bank_req_valid_o[b] && bank_req_ready_i[b]) begin
        tag_q[b] <= gnt[b];
        ptr_q[b] <= link_dir_t'(2'(gnt[b] + 1));
      end
    end
  end

endmodule

//--- hw/tcdm_bank.sv
/* Single-port TCDM word memory with a one-entry response register */
`include "mempool_defines.svh"

module tcdm_bank (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mempool_pkg::tcdm_req_t  req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output mempool_pkg::tcdm_resp_t resp_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i
);

  logic [`MEMPOOL_DATA_WIDTH-1:0] mem_q [`MEMPOOL_BANK_DEPTH];
  logic [`MEMPOOL_DATA_WIDTH-1:0] rdata_q;
  logic                           valid_q;
  logic                           req_fire;

  // Accept while the response slot is free or drains this cycle
  assign req_ready_o  = !valid_q || resp_ready_i;
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_o       = '{rdata: rdata_q};
  assign resp_valid_o = valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_fire) begin
      valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Writes answer with the written word
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.write) begin
        mem_q[req_i.addr.row] <= req_i.wdata;
        rdata_q               <= req_i.wdata;
      end else begin
        rdata_q <= mem_q[req_i.addr.row];
      end
    end
  end

endmodule

//--- hw/mempool_pkg.sv
/* TCDM types: group index, link direction, word address fields,
   request and response payloads */
`include "mempool_defines.svh"

package mempool_pkg;

  localparam int unsigned group_bits = $clog2(`MEMPOOL_NUM_GROUPS);
  localparam int unsigned bank_bits  = $clog2(`MEMPOOL_BANKS_PER_GROUP);
  localparam int unsigned row_bits   = $clog2(`MEMPOOL_BANK_DEPTH);
  // One link per XOR distance, local included
  localparam int unsigned num_links  = `MEMPOOL_NUM_GROUPS;

  typedef logic [group_bits-1:0] group_id_t;

  // Value is the XOR of source and target group index
  typedef enum logic [1:0] {
    link_local     = 2'b00,
    link_east      = 2'b01,
    link_north     = 2'b10,
    link_northeast = 2'b11
  } link_dir_t;

  typedef struct packed {
    group_id_t            group;
    logic [bank_bits-1:0] bank;
    logic [row_bits-1:0]  row;
  } tcdm_addr_t;

  typedef struct packed {
    tcdm_addr_t                     addr;
    logic                           write;
    logic [`MEMPOOL_DATA_WIDTH-1:0] wdata;
  } tcdm_req_t;

  typedef struct packed {
    logic [`MEMPOOL_DATA_WIDTH-1:0] rdata;
  } tcdm_resp_t;

endpackage

//--- hw/apb_pkg.sv
/* APB requester and completer structs for the cluster boundary */
`include "mempool_defines.svh"

package apb_pkg;

  typedef struct packed {
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`MEMPOOL_ADDR_WIDTH-1:0] paddr;
    logic [`MEMPOOL_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                           pready;
    logic                           pslverr;
    logic [`MEMPOOL_DATA_WIDTH-1:0] prdata;
  } apb_resp_t;

endpackage

//--- hw/mempool_defines.svh
/* Cluster dimensioning macros: word and address widths, group count, bank geometry */
`ifndef MEMPOOL_DEFINES_SVH
`define MEMPOOL_DEFINES_SVH

// Word size and APB byte address size
`define MEMPOOL_DATA_WIDTH 32
`define MEMPOOL_ADDR_WIDTH 32

// Four groups on a 2x2 grid
`define MEMPOOL_NUM_GROUPS 4

// Scratchpad slice per group
`define MEMPOOL_BANKS_PER_GROUP 2
`define MEMPOOL_BANK_DEPTH 16

`endif
